// ==== all.f ====
+incdir+tb
common/RiscvPkg.sv
common/RegisterBus.sv
common/DecodeBus.sv
common/ResultBus.sv
hdl/StageID.sv
hdl/StageEX.sv
hdl/StageWB.sv
hdl/ProcessorPP.sv
tb/ProcessorTb.sv

// ==== common/DecodeBus.sv ====
`timescale 1ns/1ps

interface DecodeBus;

    logic             isValid;                           // Entry holds an instruction
    RiscvPkg::AluOp   aluOp;                             // Operation for execute
    RiscvPkg::RegAddr srcAddrA;                          // rs1, zero when unused
    RiscvPkg::RegAddr srcAddrB;                          // rs2, zero when unused
    RiscvPkg::Data    dataA;                             // Register value for rs1
    RiscvPkg::Data    dataB;                             // Register value for rs2
    RiscvPkg::Data    immediate;                         // I or U immediate
    logic             useImmediate;                      // B comes from the immediate
    RiscvPkg::RegAddr regWrAddr;                         // Destination register
    logic             regWrEnable;                       // Low for x0 and unsupported ops

    modport source (
        output isValid, aluOp, srcAddrA, srcAddrB,
        output dataA, dataB, immediate, useImmediate,
        output regWrAddr, regWrEnable);

    modport sink (
        input  isValid, aluOp, srcAddrA, srcAddrB,
        input  dataA, dataB, immediate, useImmediate,
        input  regWrAddr, regWrEnable);

endinterface

// ==== common/RegisterBus.sv ====
`timescale 1ns/1ps

interface RegisterBus;

    RiscvPkg::RegAddr rdAddrA;                           // Read address port A
    RiscvPkg::RegAddr rdAddrB;                           // Read address port B
    RiscvPkg::Data    rdDataA;                           // Read data port A
    RiscvPkg::Data    rdDataB;                           // Read data port B

    // Decode side
    modport reader (
        output rdAddrA,
        output rdAddrB,
        input  rdDataA,
        input  rdDataB);

    // Register file side, data returned in the same cycle
    modport file (
        input  rdAddrA,
        input  rdAddrB,
        output rdDataA,
        output rdDataB);

endinterface

// ==== common/ResultBus.sv ====
`timescale 1ns/1ps

interface ResultBus;

    logic             isValid;                           // Entry holds an instruction
    RiscvPkg::RegAddr regWrAddr;                         // Destination register
    logic             regWrEnable;                       // Writes the register file
    RiscvPkg::Data    regWrData;                         // ALU result

    // Execute pipeline register output
    modport source (output isValid, regWrAddr, regWrEnable, regWrData);

    // Register file write and retire
    modport writer (input isValid, regWrAddr, regWrEnable, regWrData);

    // Feedback into execute operand selection
    modport bypass (input isValid, regWrAddr, regWrEnable, regWrData);

endinterface

// ==== common/RiscvPkg.sv ====
package RiscvPkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------

    localparam int XLEN      = 32;                       // Data path width
    localparam int REG_COUNT = 32;                       // Architectural registers
    localparam int REG_BITS  = $clog2(REG_COUNT);        // Register index width

    typedef logic [XLEN-1:0]     Data;                   // Register value
    typedef logic [31:0]         Inst;                   // Instruction word
    typedef logic [REG_BITS-1:0] RegAddr;                // Register index
    typedef logic [3:0]          AluOp;                  // ALU operation code
    typedef logic [6:0]          Opcode;                 // Major opcode field
    typedef logic [2:0]          Funct3;                 // funct3 field
    typedef logic [6:0]          Funct7;                 // funct7 field

    // ----------------------------------------
    // Major opcodes
    // ----------------------------------------

    localparam Opcode OPC_OP    = 7'b0110011;            // Register-register
    localparam Opcode OPC_OPIMM = 7'b0010011;            // Register-immediate
    localparam Opcode OPC_LUI   = 7'b0110111;            // Load upper immediate

    // ----------------------------------------
    // funct3 / funct7 codes
    // ----------------------------------------

    localparam Funct3 F3_ADD  = 3'b000;                  // ADD, SUB, ADDI
    localparam Funct3 F3_SLL  = 3'b001;                  // Shift left
    localparam Funct3 F3_SLT  = 3'b010;                  // Signed compare
    localparam Funct3 F3_SLTU = 3'b011;                  // Unsigned compare
    localparam Funct3 F3_XOR  = 3'b100;
    localparam Funct3 F3_SR   = 3'b101;                  // SRL or SRA
    localparam Funct3 F3_OR   = 3'b110;
    localparam Funct3 F3_AND  = 3'b111;

    localparam Funct7 F7_ALT  = 7'b0100000;              // Selects SUB and SRA

    // ----------------------------------------
    // ALU operations
    // ----------------------------------------

    localparam AluOp ALU_ADD   = 4'd0;                   // A + B
    localparam AluOp ALU_SUB   = 4'd1;                   // A - B
    localparam AluOp ALU_SLL   = 4'd2;                   // A << B[4:0]
    localparam AluOp ALU_SLT   = 4'd3;                   // Signed less than
    localparam AluOp ALU_SLTU  = 4'd4;                   // Unsigned less than
    localparam AluOp ALU_XOR   = 4'd5;                   // A ^ B
    localparam AluOp ALU_SRL   = 4'd6;                   // Logical right shift
    localparam AluOp ALU_SRA   = 4'd7;                   // Arithmetic right shift
    localparam AluOp ALU_OR    = 4'd8;                   // A | B
    localparam AluOp ALU_AND   = 4'd9;                   // A & B
    localparam AluOp ALU_PASSB = 4'd10;                  // B through, for LUI

endpackage

// ==== hdl/ProcessorPP.sv ====
`timescale 1ns/1ps

module ProcessorPP (
    input  logic             i_clock,                    // Clock
    input  logic             i_reset,                    // Reset
    input  logic             i_instValid,                // Instruction strobe
    input  RiscvPkg::Inst    i_inst,                     // Instruction word
    output logic             o_retireValid,              // Instruction retires
    output logic             o_retireRegWrEnable,        // Retire writes a register
    output RiscvPkg::RegAddr o_retireRegAddr,            // Destination register
    output RiscvPkg::Data    o_retireRegData);           // Written value


    RegisterBus regBus();                                // ID <-> register file
    DecodeBus   decBus();                                // ID -> EX
    ResultBus   resBus();                                // EX -> WB and EX bypass


    // ----------------------------------------
    // Decode
    // ----------------------------------------

    StageID
    stageID (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_instValid (i_instValid),
        .i_inst      (i_inst),
        .regBus      (regBus),
        .decBus      (decBus));

    // ----------------------------------------
    // Execute
    // ----------------------------------------

    StageEX
    stageEX (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .decBus    (decBus),
        .resBus    (resBus),                             // Registered result
        .bypassBus (resBus));                            // Same result fed back

    // ----------------------------------------
    // Writeback
    // ----------------------------------------

    StageWB
    stageWB (
        .i_clock             (i_clock),
        .i_reset             (i_reset),
        .regBus              (regBus),
        .resBus              (resBus),
        .o_retireValid       (o_retireValid),
        .o_retireRegWrEnable (o_retireRegWrEnable),
        .o_retireRegAddr     (o_retireRegAddr),
        .o_retireRegData     (o_retireRegData));

endmodule

// ==== hdl/StageEX.sv ====
`timescale 1ns/1ps

module StageEX (
    input  logic     i_clock,                            // Clock
    input  logic     i_reset,                            // Reset
    DecodeBus.sink   decBus,                             // From decode
    ResultBus.source resBus,                             // To writeback
    ResultBus.bypass bypassBus);                         // Previous result fed back


    // ----------------------------------------
    // Operand bypass
    // ----------------------------------------

    // Takes the result ahead when it writes this source register
    function automatic RiscvPkg::Data forward(
        input RiscvPkg::RegAddr srcAddr,
        input RiscvPkg::Data    regData,
        input logic             live,
        input RiscvPkg::RegAddr wrAddr,
        input RiscvPkg::Data    wrData);

        if (live && (srcAddr != '0) && (srcAddr == wrAddr))
            forward = wrData;
        else
            forward = regData;
    endfunction

    logic          bypassLive;                           // Result ahead writes a register
    RiscvPkg::Data regA;                                 // rs1 after bypass
    RiscvPkg::Data regB;                                 // rs2 after bypass
    RiscvPkg::Data operandA;
    RiscvPkg::Data operandB;

    assign bypassLive = bypassBus.isValid & bypassBus.regWrEnable;

    assign regA = forward(decBus.srcAddrA, decBus.dataA, bypassLive,
                          bypassBus.regWrAddr, bypassBus.regWrData);
    assign regB = forward(decBus.srcAddrB, decBus.dataB, bypassLive,
                          bypassBus.regWrAddr, bypassBus.regWrData);

    assign operandA = regA;
    assign operandB = decBus.useImmediate ? decBus.immediate : regB; // I/U or rs2


    // ----------------------------------------
    // ALU
    // ----------------------------------------

    logic [4:0]    shamt;                                // Shift amount
    RiscvPkg::Data result;

    assign shamt = operandB[4:0];

    always_comb begin
        case (decBus.aluOp)
            RiscvPkg::ALU_ADD:   result = operandA + operandB;
            RiscvPkg::ALU_SUB:   result = operandA - operandB;
            RiscvPkg::ALU_SLL:   result = operandA << shamt;
            RiscvPkg::ALU_SLT:   result = RiscvPkg::Data'($signed(operandA) < $signed(operandB));
            RiscvPkg::ALU_SLTU:  result = RiscvPkg::Data'(operandA < operandB);
            RiscvPkg::ALU_XOR:   result = operandA ^ operandB;
            RiscvPkg::ALU_SRL:   result = operandA >> shamt;
            RiscvPkg::ALU_SRA:   result = RiscvPkg::Data'($signed(operandA) >>> shamt);
            RiscvPkg::ALU_OR:    result = operandA | operandB;
            RiscvPkg::ALU_AND:   result = operandA & operandB;
            RiscvPkg::ALU_PASSB: result = operandB;      // LUI
            default:             result = '0;
        endcase
    end


    // ----------------------------------------
    // Pipeline EX-WB
    // ----------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            resBus.isValid     <= 1'b0;
            resBus.regWrEnable <= 1'b0;
        end
        else begin
            resBus.isValid     <= decBus.isValid;
            resBus.regWrEnable <= decBus.regWrEnable;
        end
    end

    always_ff @(posedge i_clock) begin
        resBus.regWrAddr <= decBus.regWrAddr;
        resBus.regWrData <= result;
    end

endmodule

// ==== hdl/StageID.sv ====
`timescale 1ns/1ps

module StageID (
    input  logic          i_clock,                       // Clock
    input  logic          i_reset,                       // Reset
    input  logic          i_instValid,                   // Instruction strobe
    input  RiscvPkg::Inst i_inst,                        // Instruction word
    RegisterBus.reader    regBus,                        // Register file read ports
    DecodeBus.source      decBus);                       // To execute


    // ----------------------------------------
    // Instruction fields
    // ----------------------------------------

    RiscvPkg::Opcode  opcode;
    RiscvPkg::Funct3  funct3;
    RiscvPkg::Funct7  funct7;
    RiscvPkg::RegAddr rd;
    RiscvPkg::RegAddr rs1;
    RiscvPkg::RegAddr rs2;

    assign opcode = i_inst[6:0];
    assign rd     = i_inst[11:7];
    assign funct3 = i_inst[14:12];
    assign rs1    = i_inst[19:15];
    assign rs2    = i_inst[24:20];
    assign funct7 = i_inst[31:25];

    // funct3 to ALU code, alt picks SUB / SRA
    function automatic RiscvPkg::AluOp decodeAlu(
        input RiscvPkg::Funct3 f3,
        input logic            alt);

        case (f3)
            RiscvPkg::F3_ADD:  decodeAlu = alt ? RiscvPkg::ALU_SUB : RiscvPkg::ALU_ADD;
            RiscvPkg::F3_SLL:  decodeAlu = RiscvPkg::ALU_SLL;
            RiscvPkg::F3_SLT:  decodeAlu = RiscvPkg::ALU_SLT;
            RiscvPkg::F3_SLTU: decodeAlu = RiscvPkg::ALU_SLTU;
            RiscvPkg::F3_XOR:  decodeAlu = RiscvPkg::ALU_XOR;
            RiscvPkg::F3_SR:   decodeAlu = alt ? RiscvPkg::ALU_SRA : RiscvPkg::ALU_SRL;
            RiscvPkg::F3_OR:   decodeAlu = RiscvPkg::ALU_OR;
            default:           decodeAlu = RiscvPkg::ALU_AND;
        endcase
    endfunction


    // ----------------------------------------
    // Decoder
    // ----------------------------------------

    RiscvPkg::AluOp   aluOp;                             // Decoded operation
    RiscvPkg::Data    immediate;                         // Selected immediate
    RiscvPkg::RegAddr srcAddrA;                          // rs1 or zero
    RiscvPkg::RegAddr srcAddrB;                          // rs2 or zero
    logic             useImmediate;
    logic             writesReg;                         // Supported opcode with rd

    always_comb begin
        aluOp        = RiscvPkg::ALU_ADD;
        immediate    = {{20{i_inst[31]}}, i_inst[31:20]}; // Sign-extended I-type
        srcAddrA     = '0;
        srcAddrB     = '0;
        useImmediate = 1'b0;
        writesReg    = 1'b0;

        case (opcode)
            RiscvPkg::OPC_OP: begin
                aluOp     = decodeAlu(funct3, funct7 == RiscvPkg::F7_ALT);
                srcAddrA  = rs1;
                srcAddrB  = rs2;
                writesReg = 1'b1;
            end
            RiscvPkg::OPC_OPIMM: begin                   // funct7 only matters for shifts right
                aluOp        = decodeAlu(funct3,
                    (funct3 == RiscvPkg::F3_SR) && (funct7 == RiscvPkg::F7_ALT));
                srcAddrA     = rs1;
                useImmediate = 1'b1;
                writesReg    = 1'b1;
            end
            RiscvPkg::OPC_LUI: begin
                aluOp        = RiscvPkg::ALU_PASSB;
                immediate    = {i_inst[31:12], 12'b0};   // U-type
                useImmediate = 1'b1;
                writesReg    = 1'b1;
            end
            default: ;                                   // Retires without a write
        endcase
    end

    assign regBus.rdAddrA = srcAddrA;                    // Unused ports read x0
    assign regBus.rdAddrB = srcAddrB;


    // ----------------------------------------
    // Pipeline ID-EX
    // ----------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            decBus.isValid     <= 1'b0;
            decBus.regWrEnable <= 1'b0;
        end
        else begin
            decBus.isValid     <= i_instValid;
            decBus.regWrEnable <= i_instValid & writesReg & (rd != '0); // Never x0
        end
    end

    always_ff @(posedge i_clock) begin
        decBus.aluOp        <= aluOp;
        decBus.srcAddrA     <= srcAddrA;
        decBus.srcAddrB     <= srcAddrB;
        decBus.dataA        <= regBus.rdDataA;           // Already write-first
        decBus.dataB        <= regBus.rdDataB;
        decBus.immediate    <= immediate;
        decBus.useImmediate <= useImmediate;
        decBus.regWrAddr    <= rd;
    end

endmodule

// ==== hdl/StageWB.sv ====
`timescale 1ns/1ps

module StageWB (
    input  logic              i_clock,                   // Clock
    input  logic              i_reset,                   // Reset
    RegisterBus.file          regBus,                    // Read ports from decode
    ResultBus.writer          resBus,                    // Result to write
    output logic              o_retireValid,             // Instruction retires
    output logic              o_retireRegWrEnable,       // Retire writes a register
    output RiscvPkg::RegAddr  o_retireRegAddr,           // Destination register
    output RiscvPkg::Data     o_retireRegData);          // Written value


    // ----------------------------------------
    // Register storage
    // ----------------------------------------

    RiscvPkg::Data regs [1:RiscvPkg::REG_COUNT-1];       // x0 is not stored
    logic          pendingWrite;                         // ResultBus entry writes now

    assign pendingWrite = resBus.isValid & resBus.regWrEnable;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 1; i < RiscvPkg::REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (pendingWrite && (resBus.regWrAddr != '0))
            regs[resBus.regWrAddr] <= resBus.regWrData;
    end


    // ----------------------------------------
    // Read ports, write-first
    // ----------------------------------------

    RiscvPkg::RegAddr rdAddr [2];                        // Port A, port B
    RiscvPkg::Data    rdData [2];

    assign rdAddr[0] = regBus.rdAddrA;
    assign rdAddr[1] = regBus.rdAddrB;

    always_comb begin
        for (int i = 0; i < $size(rdAddr); i++) begin
            if (rdAddr[i] == '0)
                rdData[i] = '0;                          // x0 hardwired
            else if (pendingWrite && (resBus.regWrAddr == rdAddr[i]))
                rdData[i] = resBus.regWrData;            // Value written this edge
            else
                rdData[i] = regs[rdAddr[i]];
        end
    end

    assign regBus.rdDataA = rdData[0];
    assign regBus.rdDataB = rdData[1];


    // Retire straight from the execute register
    assign o_retireValid       = resBus.isValid;
    assign o_retireRegWrEnable = resBus.regWrEnable;
    assign o_retireRegAddr     = resBus.regWrAddr;
    assign o_retireRegData     = resBus.regWrData;

endmodule

// ==== tb/ProcessorModel.svh ====
`ifndef PROCESSOR_MODEL_SVH
`define PROCESSOR_MODEL_SVH

// ----------------------------------------
// Expected retire entries
// ----------------------------------------

typedef struct packed {
    logic [31:0]      dueCycle;                          // Negedge cycle of the retire
    logic             wrEnable;                          // Register write expected
    RiscvPkg::RegAddr addr;                              // Destination register
    RiscvPkg::Data    data;                              // Value written
} RetireEntry;

RetireEntry    expected [$];                             // In accept order
RiscvPkg::Data modelRegs [32] = '{default: '0};          // Architectural registers

// Integer result per funct3 with alt selecting SUB or SRA
function automatic RiscvPkg::Data aluResult(
    input RiscvPkg::Funct3 f3,
    input logic            alt,
    input RiscvPkg::Data   a,
    input RiscvPkg::Data   b);

    RiscvPkg::Data r;

    case (f3)
        RiscvPkg::F3_ADD:  r = alt ? a - b : a + b;
        RiscvPkg::F3_SLL:  r = a << b[4:0];
        RiscvPkg::F3_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        RiscvPkg::F3_SLTU: r = (a < b) ? 32'd1 : 32'd0;
        RiscvPkg::F3_XOR:  r = a ^ b;
        RiscvPkg::F3_SR: begin
            if (alt)
                r = $signed(a) >>> b[4:0];               // Sign bits shifted in
            else
                r = a >> b[4:0];
        end
        RiscvPkg::F3_OR:   r = a | b;
        default:           r = a & b;
    endcase
    return r;
endfunction

// Random OP, OP-IMM or LUI word with about 1 in 16 unsupported
function automatic RiscvPkg::Inst randomInstruction();
    RiscvPkg::Inst   inst;
    int              kind;
    RiscvPkg::Funct3 f3;
    RiscvPkg::Funct7 f7;
    RiscvPkg::RegAddr rd;
    RiscvPkg::RegAddr rs1;
    RiscvPkg::RegAddr rs2;

    inst = $random(seed);                                // Random immediates and upper bits
    kind = $random(seed) & 15;
    rd   = RiscvPkg::RegAddr'($random(seed) & 7);        // x0-x7 only
    rs1  = RiscvPkg::RegAddr'($random(seed) & 7);
    rs2  = RiscvPkg::RegAddr'($random(seed) & 7);
    f3   = RiscvPkg::Funct3'($random(seed));
    f7   = 7'b0;
    if ((($random(seed) & 1) != 0) && (f3 == RiscvPkg::F3_ADD || f3 == RiscvPkg::F3_SR))
        f7 = RiscvPkg::F7_ALT;

    if (kind == 0) begin
        case ($random(seed) & 7)
            0:       inst[6:0] = 7'b0000011;             // Load
            1:       inst[6:0] = 7'b0100011;             // Store
            2:       inst[6:0] = 7'b1100011;             // Branch
            3:       inst[6:0] = 7'b1101111;             // JAL
            4:       inst[6:0] = 7'b1100111;             // JALR
            5:       inst[6:0] = 7'b0010111;             // AUIPC
            6:       inst[6:0] = 7'b0001111;             // Fence
            default: inst[6:0] = 7'b1110011;             // System
        endcase
    end
    else if (kind < 4) begin
        inst[11:0] = {rd, RiscvPkg::OPC_LUI};
    end
    else if (kind < 10) begin
        inst = {f7, rs2, rs1, f3, rd, RiscvPkg::OPC_OP};
    end
    else begin
        if (f3 == RiscvPkg::F3_SLL || f3 == RiscvPkg::F3_SR)
            inst[31:25] = f7;                            // Shift form with shamt in [24:20]
        inst[19:0] = {rs1, f3, rd, RiscvPkg::OPC_OPIMM};
    end
    return inst;
endfunction

// Runs one accepted instruction on the model and queues its retire
task automatic executeInstruction(input RiscvPkg::Inst inst, input int dueCycle);
    RetireEntry      entry;
    RiscvPkg::Opcode opc;
    RiscvPkg::Funct3 f3;
    logic            alt;
    RiscvPkg::Data   a;
    RiscvPkg::Data   b;
    RiscvPkg::Data   imm;

    opc = inst[6:0];
    f3  = inst[14:12];
    alt = (inst[31:25] == RiscvPkg::F7_ALT);
    a   = modelRegs[inst[19:15]];
    b   = modelRegs[inst[24:20]];
    imm = {{20{inst[31]}}, inst[31:20]};                 // Sign-extended I-type

    entry.dueCycle = dueCycle;
    entry.wrEnable = 1'b1;
    entry.addr     = inst[11:7];
    entry.data     = '0;
    if (opc == RiscvPkg::OPC_OP)
        entry.data = aluResult(f3, alt, a, b);
    else if (opc == RiscvPkg::OPC_OPIMM)
        entry.data = aluResult(f3, alt && (f3 == RiscvPkg::F3_SR), a, imm);
    else if (opc == RiscvPkg::OPC_LUI)
        entry.data = {inst[31:12], 12'b0};
    else
        entry.wrEnable = 1'b0;                           // Unsupported opcode writes nothing

    if (entry.addr == '0)
        entry.wrEnable = 1'b0;                           // x0 never written
    if (entry.wrEnable)
        modelRegs[entry.addr] = entry.data;
    expected.push_back(entry);
endtask

`endif

// ==== tb/ProcessorTb.sv ====
`timescale 1ns/1ps

module ProcessorTb;

    localparam int NUM_INST       = 2000;                // Instructions sent
    localparam int TIMEOUT_CYCLES = NUM_INST * 4 + 100;  // Run limit

    logic             i_clock;
    logic             i_reset;
    logic             i_instValid;
    RiscvPkg::Inst    i_inst;
    logic             o_retireValid;
    logic             o_retireRegWrEnable;
    RiscvPkg::RegAddr o_retireRegAddr;
    RiscvPkg::Data    o_retireRegData;

    integer seed;                                        // $random state
    int     cycleCount = 0;                              // Rising edges seen

    `include "ProcessorModel.svh"

    ProcessorPP DUT (
        .i_clock             (i_clock),
        .i_reset             (i_reset),
        .i_instValid         (i_instValid),
        .i_inst              (i_inst),
        .o_retireValid       (o_retireValid),
        .o_retireRegWrEnable (o_retireRegWrEnable),
        .o_retireRegAddr     (o_retireRegAddr),
        .o_retireRegData     (o_retireRegData));

    // Prints the cause and ends the run
    task automatic stopRun(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "Run stopped at first error");
    endtask

    initial begin
        i_clock = 1'b0;
        forever #4 i_clock = ~i_clock;                   // 8 ns period
    end

    // ----------------------------------------
    // Cycle counter and timeout
    // ----------------------------------------
    always @(posedge i_clock) begin
        cycleCount <= cycleCount + 1;
        assert (cycleCount < TIMEOUT_CYCLES) else
            stopRun($sformatf("Timeout: retires not done after %0d cycles", TIMEOUT_CYCLES));
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        RiscvPkg::Inst inst;
        int            sent;

        seed        = 32'h34b9_9160;
        sent        = 0;
        i_reset     = 1'b1;
        i_instValid = 1'b0;
        i_inst      = '0;
        repeat (5) @(posedge i_clock);
        i_reset <= 1'b0;

        while (sent < NUM_INST) begin
            @(posedge i_clock);
            if (($random(seed) & 3) != 0) begin          // 3 in 4 cycles carry a strobe
                inst = randomInstruction();
                i_instValid <= 1'b1;
                i_inst      <= inst;
                // Accepted next edge and retired one edge after that
                executeInstruction(inst, cycleCount + 3);
                sent++;
            end
            else begin
                i_instValid <= 1'b0;
            end
        end
        @(posedge i_clock);
        i_instValid <= 1'b0;

        while (expected.size() != 0)
            @(posedge i_clock);
        repeat (4) @(posedge i_clock);                   // Watch for stray retires
        $display("TB PASSED");
        $finish;
    end

    // ----------------------------------------
    // Retire checks
    // ----------------------------------------
    always @(negedge i_clock) begin : checkRetire
        RetireEntry head;

        if (!i_reset) begin
            if (expected.size() != 0 && expected[0].dueCycle == cycleCount) begin
                head = expected.pop_front();
                assert (o_retireValid === 1'b1) else
                    stopRun($sformatf("Mismatch o_retireValid: expected %h, actual %h",
                                      1'b1, o_retireValid));
                assert (o_retireRegWrEnable === head.wrEnable) else
                    stopRun($sformatf("Mismatch o_retireRegWrEnable: expected %h, actual %h",
                                      head.wrEnable, o_retireRegWrEnable));
                if (head.wrEnable) begin
                    assert (o_retireRegAddr === head.addr) else
                        stopRun($sformatf("Mismatch o_retireRegAddr: expected %h, actual %h",
                                          head.addr, o_retireRegAddr));
                    assert (o_retireRegData === head.data) else
                        stopRun($sformatf("Mismatch o_retireRegData: expected %h, actual %h",
                                          head.data, o_retireRegData));
                end
            end
            else begin
                assert (o_retireValid === 1'b0) else
                    stopRun($sformatf("Mismatch o_retireValid: expected %h, actual %h",
                                      1'b0, o_retireValid));
            end
        end
    end

endmodule
